//--- src/vlsu_config.svh
// Build-time configuration of the transaction-control slice.
// Queue depth must be a power of two and at least 2.
// Page size must be a power of two; addresses and lengths count nibbles.
`ifndef VLSU_CONFIG_SVH
`define VLSU_CONFIG_SVH

// ======================================================================
// Bus and queue
// ======================================================================

// AXI data bus width in bits
`define VLSU_AXI_DATA_W 64

// Entries in the transaction control ring
`define VLSU_TXN_DEPTH 4

// ======================================================================
// Address space
// ======================================================================

// 4 KiB page expressed in nibbles
`define VLSU_PAGE_NIB 8192
`define VLSU_ADDR_W 32
`define VLSU_ID_W 3

`endif

//--- src/vlsu_pkg.sv
// Shared types of the vector load/store transaction-control slice.
// All addresses below are nibble addresses unless the field says bytes.
`default_nettype none
`include "vlsu_config.svh"

package vlsu_pkg;

  // Derived sizes
  localparam int unsigned BUS_NIB   = `VLSU_AXI_DATA_W / 4;
  localparam int unsigned BUS_NSIZE = $clog2(BUS_NIB);
  localparam int unsigned PAGE_W    = $clog2(`VLSU_PAGE_NIB);
  localparam int unsigned TXN_W     = `VLSU_ADDR_W + 1 - PAGE_W;
  localparam int unsigned RMN_W     = PAGE_W - BUS_NSIZE;

  typedef enum logic {
    IDLE,
    EMIT
  } split_state_e;

  // AXI burst encodings
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef struct packed {
    logic [`VLSU_ADDR_W-1:0] base_addr;
    logic [`VLSU_ADDR_W-1:0] len;
    logic                    is_load;
    logic [`VLSU_ID_W-1:0]   req_id;
  } mem_req_t;

  typedef struct packed {
    logic [TXN_W-1:0]        txn_cnt;
    logic [TXN_W-1:0]        txn_num;
    logic [`VLSU_ADDR_W-1:0] seg_base_addr;
    logic [PAGE_W:0]         lt_n;
    logic                    is_load;
    logic [`VLSU_ID_W-1:0]   req_id;
  } meta_t;

  typedef struct packed {
    logic [`VLSU_ADDR_W-1:0] addr;
    logic [RMN_W-1:0]        rmn_beat;
    logic [BUS_NSIZE:0]      lb_n;
    logic                    is_head;
    logic                    is_load;
    logic                    is_final;
    logic [`VLSU_ID_W-1:0]   req_id;
  } txn_ctrl_t;

  // Byte address on the bus
  typedef struct packed {
    logic [`VLSU_ADDR_W-1:0] addr;
    logic [RMN_W-1:0]        len;
    logic [2:0]              size;
    burst_e                  burst;
  } ax_req_t;

  typedef struct packed {
    logic [`VLSU_ID_W-1:0] req_id;
    logic                  is_load;
    logic                  is_head;
    logic                  is_last;
    logic [BUS_NSIZE:0]    nib_cnt;
  } beat_info_t;

  typedef logic [(1 << `VLSU_ID_W)-1:0] done_vec_t;

endpackage

`default_nettype wire

//--- src/seg_splitter.sv
// Splits one memory request into page-bounded transactions.
// The request length must be at least one nibble.
// One transaction is offered per cycle; a new request waits for the last one.
`timescale 1ns/1ns
`default_nettype none
`include "vlsu_config.svh"

module seg_splitter (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               req_valid_i,
  output logic                    req_ready_o,
  input  wire vlsu_pkg::mem_req_t req_i,
  output logic                    meta_valid_o,
  input  wire logic               meta_ready_i,
  output vlsu_pkg::meta_t         meta_o
);

  localparam int unsigned PAGE_W = vlsu_pkg::PAGE_W;
  localparam int unsigned TXN_W  = vlsu_pkg::TXN_W;
  localparam int unsigned END_W  = `VLSU_ADDR_W + 1;

  vlsu_pkg::split_state_e  state_q;
  logic [TXN_W-1:0]        txn_cnt_q;
  logic [TXN_W-1:0]        txn_num_q;
  logic [`VLSU_ADDR_W-1:0] base_q;
  logic [PAGE_W:0]         lt_n_q;
  logic                    is_load_q;
  logic [`VLSU_ID_W-1:0]   req_id_q;

  logic [END_W-1:0] req_end;
  logic [END_W-1:0] req_end_m1;
  logic             req_fire;
  logic             meta_fire;

  // End of the request measured from the start of its first page
  assign req_end    = END_W'(req_i.base_addr[PAGE_W-1:0]) + END_W'(req_i.len);
  assign req_end_m1 = req_end - 1'b1;

  assign req_ready_o  = (state_q == vlsu_pkg::IDLE);
  assign meta_valid_o = (state_q == vlsu_pkg::EMIT);
  assign req_fire     = req_valid_i && req_ready_o;
  assign meta_fire    = meta_valid_o && meta_ready_i;

  // ======================================================================
  // Control FSM
  // ======================================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= vlsu_pkg::IDLE;
      txn_cnt_q <= '0;
    end else begin
      case (state_q)
        vlsu_pkg::IDLE: begin
          if (req_fire) begin
            state_q   <= vlsu_pkg::EMIT;
            txn_cnt_q <= '0;
          end
        end
        vlsu_pkg::EMIT: begin
          if (meta_fire) begin
            if (txn_cnt_q == txn_num_q) begin
              state_q <= vlsu_pkg::IDLE;
            end else begin
              txn_cnt_q <= txn_cnt_q + 1'b1;
            end
          end
        end
        default: state_q <= vlsu_pkg::IDLE;
      endcase
    end
  end

  // Request fields held for the whole emission
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      base_q    <= req_i.base_addr;
      txn_num_q <= req_end_m1[END_W-1:PAGE_W];
      // Last page end, page offset included
      lt_n_q    <= {1'b0, req_end_m1[PAGE_W-1:0]} + 1'b1;
      is_load_q <= req_i.is_load;
      req_id_q  <= req_i.req_id;
    end
  end

  always_comb begin
    meta_o.txn_cnt       = txn_cnt_q;
    meta_o.txn_num       = txn_num_q;
    meta_o.seg_base_addr = base_q;
    meta_o.lt_n          = lt_n_q;
    meta_o.is_load       = is_load_q;
    meta_o.req_id        = req_id_q;
  end

endmodule

`default_nettype wire

//--- src/txn_ctrl_queue.sv
// Ring of transaction control records, issued in order with AXI id zero.
// B is taken only for the oldest entry when it is a store whose beats are done.
// A full page on a 64-bit bus needs 512 beats, so len exceeds the AXI4 limit.
`timescale 1ns/1ns
`default_nettype none
`include "vlsu_config.svh"

module txn_ctrl_queue (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                meta_valid_i,
  output logic                     meta_ready_o,
  input  wire vlsu_pkg::meta_t     meta_i,
  output logic                     txn_ctrl_valid_o,
  output vlsu_pkg::txn_ctrl_t      txn_ctrl_o,
  input  wire logic                update_i,
  output logic                     ar_valid_o,
  input  wire logic                ar_ready_i,
  output vlsu_pkg::ax_req_t        ar_o,
  output logic                     aw_valid_o,
  input  wire logic                aw_ready_i,
  output vlsu_pkg::ax_req_t        aw_o,
  input  wire logic                b_valid_i,
  output logic                     b_ready_o,
  output vlsu_pkg::done_vec_t      done_o
);

  localparam int unsigned DEPTH     = `VLSU_TXN_DEPTH;
  localparam int unsigned IDX_W     = $clog2(DEPTH);
  localparam int unsigned PAGE_W    = vlsu_pkg::PAGE_W;
  localparam int unsigned BUS_NSIZE = vlsu_pkg::BUS_NSIZE;
  localparam int unsigned PIDX_W    = `VLSU_ADDR_W - PAGE_W;

  localparam logic [PAGE_W:0]    PAGE_NIB = (PAGE_W + 1)'(`VLSU_PAGE_NIB);
  localparam logic [BUS_NSIZE:0] BUS_NIB  = (BUS_NSIZE + 1)'(vlsu_pkg::BUS_NIB);
  localparam logic [2:0]         AX_SIZE  = 3'($clog2(`VLSU_AXI_DATA_W / 8));

  // Pointers carry a wrap flag in the top bit
  logic [IDX_W:0] enq_q;
  logic [IDX_W:0] iss_q;
  logic [IDX_W:0] dat_q;
  logic [IDX_W:0] deq_q;

  vlsu_pkg::txn_ctrl_t rec_q [DEPTH];
  vlsu_pkg::txn_ctrl_t new_rec;
  vlsu_pkg::txn_ctrl_t iss_rec;
  vlsu_pkg::txn_ctrl_t dat_rec;
  vlsu_pkg::txn_ctrl_t deq_rec;
  vlsu_pkg::ax_req_t   ax_req;

  logic full;
  logic do_enq;
  logic ax_valid;
  logic ax_fire;
  logic dat_adv;
  logic b_fire;
  logic do_deq;

  logic              is_head_txn;
  logic              is_last_txn;
  logic [PIDX_W-1:0] page_idx;
  logic [`VLSU_ADDR_W-1:0] txn_addr;
  logic [PAGE_W:0]   off_al;
  logic [PAGE_W:0]   nib_pg;
  logic [PAGE_W:0]   nib;
  logic [PAGE_W:0]   nib_m1;

  // ======================================================================
  // Enqueue record derivation
  // ======================================================================
  assign is_head_txn = (meta_i.txn_cnt == '0);
  assign is_last_txn = (meta_i.txn_cnt == meta_i.txn_num);
  assign page_idx    = meta_i.seg_base_addr[`VLSU_ADDR_W-1:PAGE_W] +
                       meta_i.txn_cnt[PIDX_W-1:0];
  assign txn_addr    = is_head_txn ? meta_i.seg_base_addr : {page_idx, {PAGE_W{1'b0}}};

  // Page offset rounded down to a bus word
  assign off_al = {1'b0, txn_addr[PAGE_W-1:BUS_NSIZE], {BUS_NSIZE{1'b0}}};
  assign nib_pg = is_last_txn ? meta_i.lt_n : PAGE_NIB;
  assign nib    = nib_pg - off_al;
  assign nib_m1 = nib - 1'b1;

  always_comb begin
    new_rec.addr     = txn_addr;
    new_rec.rmn_beat = nib_m1[PAGE_W-1:BUS_NSIZE];
    new_rec.lb_n     = (nib[BUS_NSIZE-1:0] != '0) ? {1'b0, nib[BUS_NSIZE-1:0]} : BUS_NIB;
    new_rec.is_head  = 1'b1;
    new_rec.is_load  = meta_i.is_load;
    // One segment per request, so the last transaction is the final one
    new_rec.is_final = is_last_txn;
    new_rec.req_id   = meta_i.req_id;
  end

  // ======================================================================
  // Handshakes
  // ======================================================================
  assign iss_rec = rec_q[iss_q[IDX_W-1:0]];
  assign dat_rec = rec_q[dat_q[IDX_W-1:0]];
  assign deq_rec = rec_q[deq_q[IDX_W-1:0]];

  assign full         = ((enq_q ^ deq_q) == {1'b1, {IDX_W{1'b0}}});
  assign meta_ready_o = !full;
  assign do_enq       = meta_valid_i && meta_ready_o;

  assign ax_valid   = (iss_q != enq_q);
  assign ar_valid_o = ax_valid && iss_rec.is_load;
  assign aw_valid_o = ax_valid && !iss_rec.is_load;
  assign ax_fire    = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);

  // Only issued entries expose their beats
  assign txn_ctrl_valid_o = (dat_q != iss_q);
  assign txn_ctrl_o       = dat_rec;
  assign dat_adv          = update_i && (dat_rec.rmn_beat == '0);

  assign b_ready_o = (dat_q != deq_q) && !deq_rec.is_load;
  assign b_fire    = b_valid_i && b_ready_o;

  // A load leaves on its last beat, or later if a store ahead held the ring
  assign do_deq = deq_rec.is_load ? ((dat_q != deq_q) || dat_adv) : b_fire;

  always_comb begin
    ax_req.addr  = iss_rec.addr >> 1;
    ax_req.len   = iss_rec.rmn_beat;
    ax_req.size  = AX_SIZE;
    ax_req.burst = vlsu_pkg::BURST_INCR;
  end

  assign ar_o = ax_req;
  assign aw_o = ax_req;

  always_comb begin
    done_o = '0;
    if (dat_adv && dat_rec.is_load && dat_rec.is_final) begin
      done_o[dat_rec.req_id] = 1'b1;
    end
    if (b_fire && deq_rec.is_final) begin
      done_o[deq_rec.req_id] = 1'b1;
    end
  end

  // ======================================================================
  // State
  // ======================================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enq_q <= '0;
      iss_q <= '0;
      dat_q <= '0;
      deq_q <= '0;
    end else begin
      if (do_enq) enq_q <= enq_q + 1'b1;
      if (ax_fire) iss_q <= iss_q + 1'b1;
      if (dat_adv) dat_q <= dat_q + 1'b1;
      if (do_deq) deq_q <= deq_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_i && (dat_rec.rmn_beat != '0)) begin
      rec_q[dat_q[IDX_W-1:0]].rmn_beat <= dat_rec.rmn_beat - 1'b1;
      rec_q[dat_q[IDX_W-1:0]].is_head  <= 1'b0;
    end
    if (do_enq) begin
      rec_q[enq_q[IDX_W-1:0]] <= new_rec;
    end
  end

endmodule

`default_nettype wire

//--- src/beat_sequencer.sv
// Paces data beats against the record at the data pointer.
// Purely combinational; a beat is taken only while a record is shown.
`timescale 1ns/1ns
`default_nettype none

module beat_sequencer (
  input  wire logic                txn_ctrl_valid_i,
  input  wire vlsu_pkg::txn_ctrl_t txn_ctrl_i,
  input  wire logic                beat_valid_i,
  output logic                     beat_ready_o,
  output logic                     update_o,
  output vlsu_pkg::beat_info_t     beat_info_o
);

  localparam int unsigned BUS_NSIZE = vlsu_pkg::BUS_NSIZE;

  // Nibbles in a full bus word
  localparam logic [BUS_NSIZE:0] FULL_NIB = (BUS_NSIZE + 1)'(vlsu_pkg::BUS_NIB);

  logic last_beat;

  // ======================================================================
  // Handshake
  // ======================================================================
  assign beat_ready_o = txn_ctrl_valid_i;

  // One update per accepted beat
  assign update_o = beat_valid_i && txn_ctrl_valid_i;

  // ======================================================================
  // Beat label
  // ======================================================================
  assign last_beat = (txn_ctrl_i.rmn_beat == '0);

  always_comb begin
    beat_info_o.req_id  = txn_ctrl_i.req_id;
    beat_info_o.is_load = txn_ctrl_i.is_load;
    beat_info_o.is_head = txn_ctrl_i.is_head;
    beat_info_o.is_last = last_beat;
    // Partial word only at the tail of a transaction
    beat_info_o.nib_cnt = last_beat ? txn_ctrl_i.lb_n : FULL_NIB;
  end

endmodule

`default_nettype wire

//--- src/vlsu_txn_top.sv
// Transaction-control slice: splitter, control ring and beat sequencer.
// AXI id is always zero; responses must return in order.
`timescale 1ns/1ns
`default_nettype none

module vlsu_txn_top (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               req_valid_i,
  output logic                    req_ready_o,
  input  wire vlsu_pkg::mem_req_t req_i,
  output logic                    ar_valid_o,
  input  wire logic               ar_ready_i,
  output vlsu_pkg::ax_req_t       ar_o,
  output logic                    aw_valid_o,
  input  wire logic               aw_ready_i,
  output vlsu_pkg::ax_req_t       aw_o,
  input  wire logic               b_valid_i,
  output logic                    b_ready_o,
  input  wire logic               beat_valid_i,
  output logic                    beat_ready_o,
  output vlsu_pkg::beat_info_t    beat_info_o,
  output vlsu_pkg::done_vec_t     done_o
);

  logic                meta_valid;
  logic                meta_ready;
  vlsu_pkg::meta_t     meta;
  logic                txn_ctrl_valid;
  vlsu_pkg::txn_ctrl_t txn_ctrl;
  logic                update;

  seg_splitter u_splitter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .meta_valid_o (meta_valid),
    .meta_ready_i (meta_ready),
    .meta_o       (meta)
  );

  txn_ctrl_queue u_queue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .meta_valid_i     (meta_valid),
    .meta_ready_o     (meta_ready),
    .meta_i           (meta),
    .txn_ctrl_valid_o (txn_ctrl_valid),
    .txn_ctrl_o       (txn_ctrl),
    .update_i         (update),
    .ar_valid_o       (ar_valid_o),
    .ar_ready_i       (ar_ready_i),
    .ar_o             (ar_o),
    .aw_valid_o       (aw_valid_o),
    .aw_ready_i       (aw_ready_i),
    .aw_o             (aw_o),
    .b_valid_i        (b_valid_i),
    .b_ready_o        (b_ready_o),
    .done_o           (done_o)
  );

  beat_sequencer u_beat_seq (
    .txn_ctrl_valid_i (txn_ctrl_valid),
    .txn_ctrl_i       (txn_ctrl),
    .beat_valid_i     (beat_valid_i),
    .beat_ready_o     (beat_ready_o),
    .update_o         (update),
    .beat_info_o      (beat_info_o)
  );

endmodule

`default_nettype wire

//--- verification/tb_vlsu_txn.sv
// Testbench for the transaction-control slice.
// Random AR/AW ready, beat and B stalls come from one fixed seed.
// Checks AX addresses, beat labels, done pulses and producer back-pressure.
`timescale 1ns/1ns
`default_nettype none
`include "vlsu_config.svh"

module tb_vlsu_txn;

  localparam int unsigned NUM_REQ = 13;
  localparam int unsigned LIMIT   = 200 * NUM_REQ + 500;
  localparam int unsigned LEN_W   = vlsu_pkg::RMN_W;
  localparam int unsigned LB_W    = vlsu_pkg::BUS_NSIZE + 1;
  localparam longint unsigned PAGE = `VLSU_PAGE_NIB;
  localparam longint unsigned WORD = `VLSU_AXI_DATA_W / 4;

  // Expected transaction for each AX handshake
  typedef struct packed {
    logic [`VLSU_ADDR_W-1:0] byte_addr;
    logic [LEN_W-1:0]        len;
    logic [LB_W-1:0]         lb_n;
    logic                    is_load;
    logic                    is_final;
    logic [`VLSU_ID_W-1:0]   req_id;
  } exp_txn_t;

  logic clk_i, rst_ni, req_valid_i, req_ready_o;
  logic ar_valid_o, ar_ready_i, aw_valid_o, aw_ready_i;
  logic b_valid_i, b_ready_o, beat_valid_i, beat_ready_o;
  vlsu_pkg::mem_req_t   req_i;
  vlsu_pkg::ax_req_t    ar_o, aw_o;
  vlsu_pkg::beat_info_t beat_info_o;
  vlsu_pkg::done_vec_t  done_o, exp_done;

  vlsu_pkg::mem_req_t req_list [NUM_REQ];
  exp_txn_t exp_q [$];
  exp_txn_t iss_q [$];
  exp_txn_t b_q [$];
  exp_txn_t b_head;
  vlsu_pkg::meta_t prev_meta;
  logic   prev_stall, beat_fire_q, b_fire_q;
  integer seed;
  logic [31:0] rnd;
  int unsigned errors, checks, done_cnt, cycles, beat_idx;

  vlsu_txn_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ======================================================================
  // Reference model
  // ======================================================================
  function automatic int unsigned ref_txn_count(vlsu_pkg::mem_req_t r);
    longint unsigned base;
    longint unsigned last;
    base = 64'(r.base_addr);
    last = base + 64'(r.len) - 1;
    return int'(last / PAGE - base / PAGE + 1);
  endfunction

  function automatic exp_txn_t ref_txn(vlsu_pkg::mem_req_t r, int unsigned k);
    longint unsigned base, req_end, pg, start_n, end_n, al_n, span, beats;
    exp_txn_t e;
    base    = 64'(r.base_addr);
    req_end = base + 64'(r.len);
    pg      = base / PAGE + 64'(k);
    start_n = (k == 0) ? base : pg * PAGE;
    end_n   = ((pg + 1) * PAGE < req_end) ? (pg + 1) * PAGE : req_end;
    // Beats count from the bus word that holds the first nibble
    al_n    = start_n - (start_n % WORD);
    span    = end_n - al_n;
    beats   = (span + WORD - 1) / WORD;
    e.byte_addr = `VLSU_ADDR_W'(start_n / 2);
    e.len       = LEN_W'(beats - 1);
    e.lb_n      = LB_W'(span - (beats - 1) * WORD);
    e.is_load   = r.is_load;
    e.is_final  = (k == ref_txn_count(r) - 1);
    e.req_id    = r.req_id;
    return e;
  endfunction

  task automatic expect_eq(input string name, input longint unsigned exp_v,
                           input longint unsigned act_v);
    checks++;
    if (exp_v != act_v) begin
      errors++;
      $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
    end
  endtask

  task automatic report_and_finish();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  task automatic check_addr(input logic is_ar, input vlsu_pkg::ax_req_t ax);
    exp_txn_t e;
    if (exp_q.size() == 0) begin
      errors++;
      $display("An address was issued while no transaction was expected");
    end else begin
      e = exp_q.pop_front();
      expect_eq("ax.is_ar", e.is_load, is_ar);
      expect_eq("ax.addr", e.byte_addr, ax.addr);
      expect_eq("ax.len", e.len, ax.len);
      expect_eq("ax.size", $clog2(`VLSU_AXI_DATA_W / 8), ax.size);
      expect_eq("ax.burst", vlsu_pkg::BURST_INCR, ax.burst);
      iss_q.push_back(e);
    end
  endtask

  task automatic check_beat();
    exp_txn_t e;
    if (iss_q.size() == 0) begin
      errors++;
      $display("A beat was accepted before any address had issued");
    end else begin
      e = iss_q[0];
      expect_eq("beat.req_id", e.req_id, beat_info_o.req_id);
      expect_eq("beat.is_load", e.is_load, beat_info_o.is_load);
      expect_eq("beat.is_head", beat_idx == 0, beat_info_o.is_head);
      expect_eq("beat.is_last", beat_idx == e.len, beat_info_o.is_last);
      expect_eq("beat.nib_cnt", (beat_idx == e.len) ? e.lb_n : WORD, beat_info_o.nib_cnt);
      if (beat_idx == e.len) begin
        void'(iss_q.pop_front());
        beat_idx = 0;
        if (!e.is_load) b_q.push_back(e);
        else if (e.is_final) exp_done[e.req_id] = 1'b1;
      end else begin
        beat_idx++;
      end
    end
  endtask

  // ======================================================================
  // Compare process sampled on the rising edge
  // ======================================================================
  always @(posedge clk_i) begin
    exp_done = '0;
    beat_fire_q = beat_valid_i && beat_ready_o;
    b_fire_q = b_valid_i && b_ready_o;
    if (rst_ni) begin
      if (beat_fire_q) check_beat();
      if (b_fire_q) begin
        if (b_q.size() == 0) begin
          errors++;
          $display("A B response was taken with no store waiting for it");
        end else begin
          b_head = b_q.pop_front();
          if (b_head.is_final) exp_done[b_head.req_id] = 1'b1;
        end
      end
      if (ar_valid_o && ar_ready_i) check_addr(1'b1, ar_o);
      if (aw_valid_o && aw_ready_i) check_addr(1'b0, aw_o);
      expect_eq("done_o", exp_done, done_o);
      done_cnt += $countones(done_o);
      // Producer must hold meta under back-pressure and take no request
      if (prev_stall && (!DUT.u_splitter.meta_valid_o || DUT.u_splitter.meta_o != prev_meta)) begin
        errors++;
        $display("Producer changed its stalled transaction metadata");
      end
      prev_stall = DUT.u_splitter.meta_valid_o && !DUT.u_queue.meta_ready_o;
      prev_meta  = DUT.u_splitter.meta_o;
      if (prev_stall && req_ready_o) begin
        errors++;
        $display("Request ready was high while the queue was full");
      end
    end
  end

  // AXI responder and data channel driven on the falling edge
  initial begin
    forever begin
      @(negedge clk_i);
      rnd = $random(seed);
      ar_ready_i = rnd[0];
      aw_ready_i = rnd[1];
      if (!(beat_valid_i && !beat_fire_q)) beat_valid_i = (rnd[3:2] != 2'b00);
      // B is also offered before any store is ready for it
      if (!(b_valid_i && !b_fire_q)) b_valid_i = rnd[4];
    end
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    errors++;
    $display("Timeout after %0d cycles with %0d of %0d requests done",
             cycles, done_cnt, NUM_REQ);
    report_and_finish();
  end

  // ======================================================================
  // Stimulus
  // ======================================================================
  initial begin
    seed = 32'h263c;
    errors = 0;
    checks = 0;
    done_cnt = 0;
    beat_idx = 0;
    prev_stall = 1'b0;
    beat_fire_q = 1'b0;
    b_fire_q = 1'b0;
    rst_ni = 1'b0;
    req_valid_i = 1'b0;
    req_i = '0;
    ar_ready_i = 1'b0;
    aw_ready_i = 1'b0;
    b_valid_i = 1'b0;
    beat_valid_i = 1'b0;
    // Single page, page crossings and a three-page load
    req_list[0] = '{32'h0000_0105, 32'd37, 1'b1, 3'd0};
    req_list[1] = '{32'h0000_3FEA, 32'd50, 1'b1, 3'd1};
    req_list[2] = '{32'h0000_6403, 32'd20, 1'b0, 3'd2};
    req_list[3] = '{32'h0000_9FF8, 32'd40, 1'b0, 3'd3};
    req_list[4] = '{32'h0000_DFF8, 32'd8224, 1'b1, 3'd4};
    for (int i = 5; i < NUM_REQ; i++) begin
      rnd = $random(seed);
      req_list[i].base_addr = {14'd0, 1'b1, rnd[11:8], 13'h1FC0 + 13'(rnd[5:0])};
      req_list[i].len       = 32'd1 + 32'(rnd[22:16]);
      req_list[i].is_load   = rnd[7];
      req_list[i].req_id    = 3'(i);
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < NUM_REQ; i++) begin
      @(negedge clk_i);
      req_valid_i = 1'b1;
      req_i = req_list[i];
      for (int k = 0; k < ref_txn_count(req_list[i]); k++) begin
        exp_q.push_back(ref_txn(req_list[i], k));
      end
      @(posedge clk_i);
      while (!req_ready_o) @(posedge clk_i);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (done_cnt < NUM_REQ) @(posedge clk_i);
    repeat (20) @(posedge clk_i);
    expect_eq("done.count", NUM_REQ, done_cnt);
    expect_eq("left.addresses", 0, exp_q.size());
    expect_eq("left.beats", 0, iss_q.size());
    expect_eq("left.b", 0, b_q.size());
    report_and_finish();
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+src
src/vlsu_pkg.sv
src/seg_splitter.sv
src/txn_ctrl_queue.sv
src/beat_sequencer.sv
src/vlsu_txn_top.sv
verification/tb_vlsu_txn.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 -Wno-fatal -f all.f --top-module tb_vlsu_txn -o tb_vlsu_txn \
  > build.log 2>&1 \
  && ./obj_dir/tb_vlsu_txn > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "CHECKS FAILED" sim.log \
  && { echo "Simulation FAILED, see sim.log"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }
